// File: verif/tl2umi_tests.txt
// op size source mask address a_data | exp_len exp_dstaddr exp_req_data
// resp_data exp_d_data   (all hex, one transaction per line)
1 3 03 0c 1000 1122334455667788 01 1002 112233445566 0 0
4 2 05 f0 2004 0 03 2004 0 a1b2c3d4 a1b2c3d400000000
0 3 1f ff 3000 0123456789abcdef 07 3000 0123456789abcdef 0 0
5 0 02 01 4000 0 00 0 0 0 0
4 0 07 20 5005 0 00 5005 0 5a 5a0000000000
1 1 0a c0 6006 beef000000000000 01 6006 beef 0 0
4 3 11 ff abcdef8 0 07 abcdef8 0 fedcba9876543210 fedcba9876543210
1 3 12 3c 7000 0000aabbccdd0000 03 7002 aabbccdd 0 0
4 1 1e 0c 8002 0 01 8002 0 9a3c 9a3c0000
1 0 00 80 9007 7700000000000000 00 9007 77 0 0

// File: filelist.f
rtl/tl_umi_pkg.sv
rtl/tl_req_encoder.sv
rtl/umi_req_fifo.sv
rtl/umi_resp_decoder.sv
rtl/tl2umi_bridge.sv
verif/tl2umi_assertions.sv
verif/tb_tl2umi.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TileLink to UMI bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_tl2umi \
    -f filelist.f -o sim_tl2umi > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tl2umi > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

// File: verif/tb_tl2umi.sv
`timescale 1ns/100ps
`default_nettype none

module tb_tl2umi;

    localparam int NUM_TESTS = 10;
    localparam int COLS = 11;
    localparam int CYCLE_LIMIT = 200 * NUM_TESTS + 100;
    localparam logic [15:0] CHIPID = 16'h00C5;
    localparam logic [15:0] ROUTING = 16'h0A0B;

    // Columns of one test line
    localparam int C_OP = 0;
    localparam int C_SIZE = 1;
    localparam int C_SRC = 2;
    localparam int C_MASK = 3;
    localparam int C_ADDR = 4;
    localparam int C_WDATA = 5;
    localparam int C_LEN = 6;
    localparam int C_DST = 7;
    localparam int C_UDATA = 8;
    localparam int C_RDATA = 9;
    localparam int C_DDATA = 10;

    logic                 clk;
    logic                 nreset;
    logic                 tl_a_valid;
    logic                 tl_a_ready;
    tl_umi_pkg::tl_a_t    tl_a;
    logic                 tl_d_valid;
    logic                 tl_d_ready;
    tl_umi_pkg::tl_d_t    tl_d;
    logic [1:0]           tl_d_param;
    logic                 tl_d_sink;
    logic                 tl_d_denied;
    logic                 tl_d_corrupt;
    logic                 uhost_req_valid;
    logic                 uhost_req_ready;
    tl_umi_pkg::umi_pkt_t uhost_req;
    logic                 uhost_resp_valid;
    logic                 uhost_resp_ready;
    tl_umi_pkg::umi_pkt_t uhost_resp;

    logic [63:0] tests [NUM_TESTS*COLS];
    int          req_q[$];
    int          rsp_q[$];
    int          open_txns;
    int          done_txns;
    int          num_txns;
    int          cycles = 0;
    bit          a_done;
    int unsigned seed_val;

    tl2umi_bridge #(
        .IDW        (16),
        .FIFO_DEPTH (2)
    ) dut_i (
        .clk              (clk),
        .nreset           (nreset),
        .chipid           (CHIPID),
        .local_routing    (ROUTING),
        .tl_a_valid       (tl_a_valid),
        .tl_a_ready       (tl_a_ready),
        .tl_a             (tl_a),
        .tl_d_valid       (tl_d_valid),
        .tl_d_ready       (tl_d_ready),
        .tl_d             (tl_d),
        .tl_d_param       (tl_d_param),
        .tl_d_sink        (tl_d_sink),
        .tl_d_denied      (tl_d_denied),
        .tl_d_corrupt     (tl_d_corrupt),
        .uhost_req_valid  (uhost_req_valid),
        .uhost_req_ready  (uhost_req_ready),
        .uhost_req        (uhost_req),
        .uhost_resp_valid (uhost_resp_valid),
        .uhost_resp_ready (uhost_resp_ready),
        .uhost_resp       (uhost_resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_failure("Timeout: transactions did not complete within the cycle limit");
        end
    end

    function automatic logic [63:0] test_field(input int t, input int c);
        return tests[t * COLS + c];
    endfunction

    function automatic bit is_txn(input int t);
        logic [63:0] op;
        op = test_field(t, C_OP);
        return (op == 64'd0) || (op == 64'd1) || (op == 64'd4);
    endfunction

    // Chip, routing, offset, size and source fields of the UMI source address
    function automatic logic [63:0] expected_srcaddr(input int t);
        logic [63:0] dst;
        logic [63:0] size;
        logic [63:0] src;
        dst = test_field(t, C_DST);
        size = test_field(t, C_SIZE);
        src = test_field(t, C_SRC);
        return ({48'd0, CHIPID} << 40) | ({48'd0, ROUTING} << 24) |
               ({61'd0, dst[2:0]} << 20) | ({61'd0, size[2:0]} << 16) |
               ({59'd0, src[4:0]} << 8);
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure("Value check failed");
        end
    endtask

    task automatic drive_requests();
        logic [63:0] op;
        logic [63:0] size;
        logic [63:0] src;
        logic [63:0] addr;
        logic [63:0] mask;
        for (int t = 0; t < NUM_TESTS; t++) begin
            op = test_field(t, C_OP);
            size = test_field(t, C_SIZE);
            src = test_field(t, C_SRC);
            addr = test_field(t, C_ADDR);
            mask = test_field(t, C_MASK);
            tl_a = tl_umi_pkg::tl_a_t'({op[2:0], size[2:0], src[4:0], addr[55:0],
                                        mask[7:0], test_field(t, C_WDATA)});
            tl_a_valid = 1'b1;
            do @(negedge clk); while (!tl_a_ready);
            if (is_txn(t)) begin
                // Previous D beat must be done before the next request goes in
                check_value("open transactions at accept", 64'(open_txns), 64'd0);
                open_txns++;
                req_q.push_back(t);
            end
            @(posedge clk);
            #1;
            tl_a_valid = 1'b0;
            @(negedge clk);
            check_value("tl_a_ready after accept", 64'(tl_a_ready),
                        is_txn(t) ? 64'd0 : 64'd1);
            @(posedge clk);
            #1;
        end
        a_done = 1'b1;
    endtask

    task automatic play_umi_device();
        int                   t;
        bit                   is_get;
        logic [63:0]          src;
        tl_umi_pkg::umi_pkt_t rsp;
        forever begin
            do @(negedge clk); while (!(uhost_req_valid && uhost_req_ready));
            if (req_q.size() == 0) begin
                stop_with_failure("UMI request seen with no TileLink request pending");
            end
            t = req_q.pop_front();
            is_get = (test_field(t, C_OP) == 64'd4);
            src = expected_srcaddr(t);
            check_value("uhost_req.cmd.opcode", 64'(uhost_req.cmd.opcode),
                        is_get ? 64'd1 : 64'd3);
            check_value("uhost_req.cmd.eom", 64'(uhost_req.cmd.eom), 64'd1);
            check_value("uhost_req.cmd.len", 64'(uhost_req.cmd.len), test_field(t, C_LEN));
            check_value("uhost_req.dstaddr", uhost_req.dstaddr, test_field(t, C_DST));
            check_value("uhost_req.srcaddr", uhost_req.srcaddr, src);
            if (!is_get) begin
                check_value("uhost_req.data", uhost_req.data, test_field(t, C_UDATA));
            end
            // Device echoes the source address back as dstaddr
            rsp = '0;
            rsp.cmd.eom = 1'b1;
            rsp.cmd.opcode = is_get ? tl_umi_pkg::UMI_RESP_READ : tl_umi_pkg::UMI_RESP_WRITE;
            rsp.dstaddr = src;
            rsp.data = is_get ? test_field(t, C_RDATA) : 64'd0;
            @(posedge clk);
            #1;
            uhost_resp = rsp;
            uhost_resp_valid = 1'b1;
            do @(negedge clk); while (!uhost_resp_ready);
            rsp_q.push_back(t);
            @(posedge clk);
            #1;
            uhost_resp_valid = 1'b0;
        end
    endtask

    task automatic check_d_beats();
        int t;
        bit is_get;
        forever begin
            @(negedge clk);
            if (tl_d_valid && tl_d_ready) begin
                if (rsp_q.size() == 0) begin
                    stop_with_failure("TileLink D beat seen with no UMI response pending");
                end
                t = rsp_q.pop_front();
                is_get = (test_field(t, C_OP) == 64'd4);
                check_value("tl_d.opcode", 64'(tl_d.opcode), is_get ? 64'd1 : 64'd0);
                check_value("tl_d.size", 64'(tl_d.size), test_field(t, C_SIZE));
                check_value("tl_d.source", 64'(tl_d.source), test_field(t, C_SRC));
                check_value("tl_d.data", tl_d.data, is_get ? test_field(t, C_DDATA) : 64'd0);
                check_value("tl_d_param", 64'(tl_d_param), 64'd0);
                check_value("tl_d_sink", 64'(tl_d_sink), 64'd0);
                check_value("tl_d_denied", 64'(tl_d_denied), 64'd0);
                check_value("tl_d_corrupt", 64'(tl_d_corrupt), 64'd0);
                open_txns--;
                done_txns++;
            end
        end
    endtask

    task automatic apply_stalls();
        forever begin
            @(posedge clk);
            #1;
            uhost_req_ready = (($urandom % 4) != 0);
            tl_d_ready = (($urandom % 3) != 0);
        end
    endtask

    initial begin
        seed_val = $urandom(32'h8105_571f);
        nreset = 1'b0;
        tl_a_valid = 1'b0;
        tl_a = '0;
        tl_d_ready = 1'b0;
        uhost_req_ready = 1'b0;
        uhost_resp_valid = 1'b0;
        uhost_resp = '0;
        open_txns = 0;
        done_txns = 0;
        num_txns = 0;
        a_done = 1'b0;
        $readmemh("verif/tl2umi_tests.txt", tests);
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (is_txn(t)) begin
                num_txns++;
            end
        end
        repeat (16) @(posedge clk);
        #1;
        nreset = 1'b1;
        fork
            drive_requests();
            play_umi_device();
            check_d_beats();
            apply_stalls();
        join_none
        wait (a_done && (done_txns == num_txns));
        @(posedge clk);
        @(negedge clk);
        // Bridge idle once the last D beat is gone
        check_value("tl_d_valid at end", 64'(tl_d_valid), 64'd0);
        check_value("uhost_req_valid at end", 64'(uhost_req_valid), 64'd0);
        check_value("tl_a_ready at end", 64'(tl_a_ready), 64'd1);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tl2umi_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module tl2umi_assertions (
    input logic                 clk,
    input logic                 nreset,
    input logic                 tl_a_valid,
    input logic                 tl_a_ready,
    input tl_umi_pkg::tl_a_t    tl_a,
    input logic                 tl_d_valid,
    input logic                 tl_d_ready,
    input tl_umi_pkg::tl_d_t    tl_d,
    input logic                 uhost_req_valid,
    input logic                 uhost_req_ready,
    input tl_umi_pkg::umi_pkt_t uhost_req
);

    logic txn_open;
    logic a_accept;

    // Only Get and Put open a transaction
    assign a_accept = tl_a_valid && tl_a_ready &&
                      ((tl_a.opcode == tl_umi_pkg::TL_GET) ||
                       (tl_a.opcode == tl_umi_pkg::TL_PUT_FULL_DATA) ||
                       (tl_a.opcode == tl_umi_pkg::TL_PUT_PARTIAL_DATA));

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            txn_open <= 1'b0;
        end else if (a_accept) begin
            txn_open <= 1'b1;
        end else if (tl_d_valid && tl_d_ready) begin
            txn_open <= 1'b0;
        end
    end

    d_stable: assert property (@(posedge clk) disable iff (!nreset)
        tl_d_valid && !tl_d_ready |=> tl_d_valid && $stable(tl_d))
        else $error("tl_d changed while stalled");

    req_stable: assert property (@(posedge clk) disable iff (!nreset)
        uhost_req_valid && !uhost_req_ready |=> uhost_req_valid && $stable(uhost_req))
        else $error("uhost_req changed while stalled");

    a_blocked: assert property (@(posedge clk) disable iff (!nreset)
        txn_open |-> !tl_a_ready)
        else $error("tl_a_ready high with a transaction open");

endmodule

bind tl2umi_bridge tl2umi_assertions asserts_i (
    .clk             (clk),
    .nreset          (nreset),
    .tl_a_valid      (tl_a_valid),
    .tl_a_ready      (tl_a_ready),
    .tl_a            (tl_a),
    .tl_d_valid      (tl_d_valid),
    .tl_d_ready      (tl_d_ready),
    .tl_d            (tl_d),
    .uhost_req_valid (uhost_req_valid),
    .uhost_req_ready (uhost_req_ready),
    .uhost_req       (uhost_req)
);

`default_nettype wire

// File: rtl/tl2umi_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tl2umi_bridge #(
    parameter int IDW        = 16,
    parameter int FIFO_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic [IDW-1:0]       chipid,
    input  logic [15:0]          local_routing,

    // TileLink A
    input  logic                 tl_a_valid,
    output logic                 tl_a_ready,
    input  tl_umi_pkg::tl_a_t    tl_a,

    // TileLink D
    output logic                 tl_d_valid,
    input  logic                 tl_d_ready,
    output tl_umi_pkg::tl_d_t    tl_d,
    output logic [1:0]           tl_d_param,
    output logic                 tl_d_sink,
    output logic                 tl_d_denied,
    output logic                 tl_d_corrupt,

    // UMI host port
    output logic                 uhost_req_valid,
    input  logic                 uhost_req_ready,
    output tl_umi_pkg::umi_pkt_t uhost_req,
    input  logic                 uhost_resp_valid,
    output logic                 uhost_resp_ready,
    input  tl_umi_pkg::umi_pkt_t uhost_resp
);

    logic                 wr_valid;
    logic                 wr_ready;
    tl_umi_pkg::umi_pkt_t wr_pkt;
    logic                 txn_done;

    tl_req_encoder #(
        .IDW (IDW)
    ) encoder_i (
        .clk           (clk),
        .nreset        (nreset),
        .tl_a_valid    (tl_a_valid),
        .tl_a_ready    (tl_a_ready),
        .tl_a          (tl_a),
        .chipid        (chipid),
        .local_routing (local_routing),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr_pkt        (wr_pkt),
        .txn_done      (txn_done)
    );

    umi_req_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk      (clk),
        .nreset   (nreset),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_pkt   (wr_pkt),
        .rd_valid (uhost_req_valid),
        .rd_ready (uhost_req_ready),
        .rd_pkt   (uhost_req)
    );

    umi_resp_decoder decoder_i (
        .clk              (clk),
        .nreset           (nreset),
        .uhost_resp_valid (uhost_resp_valid),
        .uhost_resp_ready (uhost_resp_ready),
        .uhost_resp       (uhost_resp),
        .tl_d_valid       (tl_d_valid),
        .tl_d_ready       (tl_d_ready),
        .tl_d             (tl_d),
        .txn_done         (txn_done)
    );

    // No denial or corruption is ever reported
    assign tl_d_param = 2'b00;
    assign tl_d_sink = 1'b0;
    assign tl_d_denied = 1'b0;
    assign tl_d_corrupt = 1'b0;

endmodule

`default_nettype wire

// File: rtl/umi_resp_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module umi_resp_decoder (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 uhost_resp_valid,
    output logic                 uhost_resp_ready,
    input  tl_umi_pkg::umi_pkt_t uhost_resp,
    output logic                 tl_d_valid,
    input  logic                 tl_d_ready,
    output tl_umi_pkg::tl_d_t    tl_d,
    output logic                 txn_done
);

    typedef enum logic {
        IDLE,
        HOLD
    } resp_state_e;

    resp_state_e state;

    tl_umi_pkg::byte_off_t  resp_off;
    tl_umi_pkg::tl_size_t   resp_size;
    tl_umi_pkg::tl_source_t resp_source;
    logic                   resp_fire;
    logic                   is_read;
    logic                   is_write;

    // Echoed source address fields
    assign resp_off =
        uhost_resp.dstaddr[tl_umi_pkg::SRC_OFF_LSB +: $bits(tl_umi_pkg::byte_off_t)];
    assign resp_size =
        uhost_resp.dstaddr[tl_umi_pkg::SRC_SIZE_LSB +: $bits(tl_umi_pkg::tl_size_t)];
    assign resp_source =
        uhost_resp.dstaddr[tl_umi_pkg::SRC_SOURCE_LSB +: $bits(tl_umi_pkg::tl_source_t)];

    assign resp_fire = uhost_resp_valid & uhost_resp_ready;
    assign is_read = (uhost_resp.cmd.opcode == tl_umi_pkg::UMI_RESP_READ);
    assign is_write = (uhost_resp.cmd.opcode == tl_umi_pkg::UMI_RESP_WRITE);

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    // Unknown responses are dropped without a beat
                    if (resp_fire && (is_read || is_write)) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (tl_d_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fire) begin
            tl_d.size <= resp_size;
            tl_d.source <= resp_source;
            if (is_read) begin
                tl_d.opcode <= tl_umi_pkg::TL_ACCESS_ACK_DATA;
                tl_d.data <= uhost_resp.data << {resp_off, 3'b000};
            end else begin
                tl_d.opcode <= tl_umi_pkg::TL_ACCESS_ACK;
                tl_d.data <= '0;
            end
        end
    end

    assign uhost_resp_ready = (state == IDLE);
    assign tl_d_valid = (state == HOLD);
    // Frees the encoder for the next A beat
    assign txn_done = tl_d_valid & tl_d_ready;

endmodule

`default_nettype wire

// File: rtl/umi_req_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module umi_req_fifo #(
    parameter int DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 wr_valid,
    output logic                 wr_ready,
    input  tl_umi_pkg::umi_pkt_t wr_pkt,
    output logic                 rd_valid,
    input  logic                 rd_ready,
    output tl_umi_pkg::umi_pkt_t rd_pkt
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    tl_umi_pkg::umi_pkt_t mem [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign push = wr_valid & wr_ready;
    assign pop = rd_valid & rd_ready;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_pkt;
        end
    end

    assign wr_ready = (count != CW'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_pkt = mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/tl_req_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module tl_req_encoder #(
    parameter int IDW = 16
) (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 tl_a_valid,
    output logic                 tl_a_ready,
    input  tl_umi_pkg::tl_a_t    tl_a,
    input  logic [IDW-1:0]       chipid,
    input  logic [15:0]          local_routing,
    output logic                 wr_valid,
    input  logic                 wr_ready,
    output tl_umi_pkg::umi_pkt_t wr_pkt,
    input  logic                 txn_done
);

    localparam int OFF_BITS = $clog2(tl_umi_pkg::BYTES_PER_WORD);
    localparam int ADDR_W = $bits(tl_umi_pkg::tl_addr_t);

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_ACK
    } req_state_e;

    req_state_e state;

    tl_umi_pkg::byte_off_t offset;
    tl_umi_pkg::umi_len_t  put_len;
    tl_umi_pkg::umi_len_t  get_len;
    tl_umi_pkg::umi_addr_t dstaddr;
    tl_umi_pkg::umi_addr_t srcaddr;
    tl_umi_pkg::umi_pkt_t  next_pkt;
    logic                  a_fire;
    logic                  is_get;
    logic                  is_put;

    assign a_fire = tl_a_valid & tl_a_ready;
    assign is_get = (tl_a.opcode == tl_umi_pkg::TL_GET);
    assign is_put = (tl_a.opcode == tl_umi_pkg::TL_PUT_FULL_DATA) ||
                    (tl_a.opcode == tl_umi_pkg::TL_PUT_PARTIAL_DATA);

    // Lowest set mask bit
    always_comb begin
        offset = tl_umi_pkg::byte_off_t'(tl_umi_pkg::BYTES_PER_WORD);
        for (int i = tl_umi_pkg::BYTES_PER_WORD - 1; i >= 0; i--) begin
            if (tl_a.mask[i]) begin
                offset = tl_umi_pkg::byte_off_t'(i);
            end
        end
    end

    // Mask population minus one, starting from all ones
    always_comb begin
        put_len = '1;
        for (int i = 0; i < tl_umi_pkg::BYTES_PER_WORD; i++) begin
            put_len = put_len + tl_umi_pkg::umi_len_t'(tl_a.mask[i]);
        end
    end

    assign get_len = tl_umi_pkg::umi_len_t'((16'd1 << tl_a.size) - 16'd1);

    assign dstaddr = tl_umi_pkg::umi_addr_t'({tl_a.address[ADDR_W-1:OFF_BITS],
                                              offset[OFF_BITS-1:0]});

    // Return path info rides in the source address
    always_comb begin
        srcaddr = '0;
        srcaddr[tl_umi_pkg::SRC_CHIP_LSB +: IDW] = chipid;
        srcaddr[tl_umi_pkg::SRC_ROUTE_LSB +: 16] = local_routing;
        srcaddr[tl_umi_pkg::SRC_OFF_LSB +: $bits(tl_umi_pkg::byte_off_t)] = offset;
        srcaddr[tl_umi_pkg::SRC_SIZE_LSB +: $bits(tl_umi_pkg::tl_size_t)] = tl_a.size;
        srcaddr[tl_umi_pkg::SRC_SOURCE_LSB +: $bits(tl_umi_pkg::tl_source_t)] = tl_a.source;
    end

    always_comb begin
        next_pkt = '0;
        next_pkt.cmd.eom = 1'b1;
        next_pkt.dstaddr = dstaddr;
        next_pkt.srcaddr = srcaddr;
        if (is_get) begin
            next_pkt.cmd.opcode = tl_umi_pkg::UMI_REQ_READ;
            next_pkt.cmd.len = get_len;
        end else begin
            next_pkt.cmd.opcode = tl_umi_pkg::UMI_REQ_WRITE;
            next_pkt.cmd.len = put_len;
            next_pkt.data = tl_a.data >> {offset, 3'b000};
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    // Other opcodes are swallowed here
                    if (a_fire && (is_get || is_put)) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (wr_ready) begin
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (txn_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire && (is_get || is_put)) begin
            wr_pkt <= next_pkt;
        end
    end

    assign tl_a_ready = (state == IDLE);
    assign wr_valid = (state == SEND);

endmodule

`default_nettype wire

// File: rtl/tl_umi_pkg.sv
`default_nettype none

package tl_umi_pkg;

    // Widths with a meaning of their own
    typedef logic [2:0]  tl_size_t;
    typedef logic [4:0]  tl_source_t;
    typedef logic [7:0]  tl_mask_t;
    typedef logic [3:0]  byte_off_t;
    typedef logic [55:0] tl_addr_t;
    typedef logic [63:0] word_t;
    typedef logic [63:0] umi_addr_t;
    typedef logic [7:0]  umi_len_t;

    typedef enum logic [2:0] {
        TL_PUT_FULL_DATA    = 3'd0,
        TL_PUT_PARTIAL_DATA = 3'd1,
        TL_GET              = 3'd4
    } tl_a_opcode_e;

    typedef enum logic [2:0] {
        TL_ACCESS_ACK      = 3'd0,
        TL_ACCESS_ACK_DATA = 3'd1
    } tl_d_opcode_e;

    typedef enum logic [4:0] {
        UMI_REQ_READ   = 5'd1,
        UMI_RESP_READ  = 5'd2,
        UMI_REQ_WRITE  = 5'd3,
        UMI_RESP_WRITE = 5'd4
    } umi_opcode_e;

    // Mask-less subset of the UMI command word
    typedef struct packed {
        logic [8:0]  reserved_hi;
        logic        eom;
        logic [5:0]  reserved_lo;
        umi_len_t    len;
        logic [2:0]  size;
        umi_opcode_e opcode;
    } umi_cmd_t;

    typedef struct packed {
        umi_cmd_t  cmd;
        umi_addr_t dstaddr;
        umi_addr_t srcaddr;
        word_t     data;
    } umi_pkt_t;

    typedef struct packed {
        tl_a_opcode_e opcode;
        tl_size_t     size;
        tl_source_t   source;
        tl_addr_t     address;
        tl_mask_t     mask;
        word_t        data;
    } tl_a_t;

    typedef struct packed {
        tl_d_opcode_e opcode;
        tl_size_t     size;
        tl_source_t   source;
        word_t        data;
    } tl_d_t;

    // Field positions in the UMI source address, echoed back as dstaddr
    localparam int SRC_SOURCE_LSB = 8;
    localparam int SRC_SIZE_LSB   = 16;
    localparam int SRC_OFF_LSB    = 20;
    localparam int SRC_ROUTE_LSB  = 24;
    localparam int SRC_CHIP_LSB   = 40;

    localparam int BYTES_PER_WORD = 8;

endpackage

`default_nettype wire
